/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int INST_W    = 32;
    localparam int OPCODE_W  = 5;
    localparam int FUNCT3_W  = 3;
    localparam int REG_IDX_W = 5;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Major opcodes, inst[6:2]
    typedef enum logic [OPCODE_W-1:0] {
        OPC_LOAD      = 5'b00000,
        OPC_ARI_ITYPE = 5'b00100,
        OPC_AUIPC     = 5'b00101,
        OPC_STORE     = 5'b01000,
        OPC_ARI_RTYPE = 5'b01100,
        OPC_LUI       = 5'b01101,
        OPC_BRANCH    = 5'b11000,
        OPC_JALR      = 5'b11001,
        OPC_JAL       = 5'b11011
    } opcode_e;

    typedef enum logic [FUNCT3_W-1:0] {
        FNC_LB  = 3'b000,
        FNC_LH  = 3'b001,
        FNC_LW  = 3'b010,
        FNC_LBU = 3'b100,
        FNC_LHU = 3'b101
    } funct3_load_e;

    typedef enum logic [FUNCT3_W-1:0] {
        FNC_SB = 3'b000,
        FNC_SH = 3'b001,
        FNC_SW = 3'b010
    } funct3_store_e;

    function automatic opcode_e inst_opcode(input logic [INST_W-1:0] inst);
        return opcode_e'(inst[6:2]);
    endfunction

    function automatic logic [FUNCT3_W-1:0] inst_funct3(input logic [INST_W-1:0] inst);
        return inst[14:12];
    endfunction

    function automatic reg_idx_t inst_rd(input logic [INST_W-1:0] inst);
        return inst[11:7];
    endfunction

    function automatic reg_idx_t inst_rs2(input logic [INST_W-1:0] inst);
        return inst[24:20];
    endfunction

    // Opcodes that write a destination register
    function automatic logic writes_rd(input opcode_e op);
        return op inside {OPC_LOAD, OPC_ARI_ITYPE, OPC_ARI_RTYPE, OPC_JAL,
                          OPC_JALR, OPC_LUI, OPC_AUIPC};
    endfunction

endpackage

/* source/mem_stage_pkg.sv */
package mem_stage_pkg;

    typedef logic [31:0] word_t;
    typedef logic [1:0]  byte_off_t;
    typedef logic [3:0]  byte_mask_t;

    typedef enum logic [2:0] {
        NONE   = 3'd0,
        BYTE_S = 3'd1,
        BYTE_U = 3'd2,
        HALF_S = 3'd3,
        HALF_U = 3'd4,
        WORD   = 3'd5
    } load_kind_e;

    // Memory-mapped I/O write ports
    localparam word_t IO_ADDR_A = 32'h8000_0008;
    localparam word_t IO_ADDR_B = 32'h8000_0018;

    // Decode to memory, 14 bits
    typedef struct packed {
        logic       dmem_en;
        byte_mask_t we;
        logic       io_en;
        logic       io_sel;
        logic       din_sel;
        logic       imem_wr;
        load_kind_e load_kind;
        byte_off_t  offset;
    } mem_ctrl_t;

    // Store data is already in its byte lanes
    typedef struct packed {
        mem_ctrl_t ctrl;
        word_t     addr;
        word_t     wdata;
    } mem_req_t;

    typedef struct packed {
        logic       valid;
        load_kind_e load_kind;
        byte_off_t  offset;
    } load_tag_t;

    typedef struct packed {
        logic  valid;
        logic  io_sel;
        word_t data;
    } io_req_t;

endpackage

/* source/mem_control.sv */
`timescale 1ns/1ps

module mem_control (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  mem_stage_pkg::word_t     inst,
    input  mem_stage_pkg::word_t     wb_inst,
    input  mem_stage_pkg::word_t     pc,
    input  mem_stage_pkg::word_t     addr,
    output mem_stage_pkg::mem_ctrl_t ctrl,
    output logic                     br_inst
);

    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    opcode_e    opcode;
    opcode_e    wb_opcode;
    logic [2:0] funct3;
    reg_idx_t   rs2;
    reg_idx_t   wb_rd;
    logic       is_io;
    logic       boot_wr;
    logic       fwd_hit;
    byte_mask_t st_mask;

    assign opcode    = inst_opcode(inst);
    assign wb_opcode = inst_opcode(wb_inst);
    assign funct3    = inst_funct3(inst);
    assign rs2       = inst_rs2(inst);
    assign wb_rd     = inst_rd(wb_inst);

    assign is_io   = (addr == IO_ADDR_A) || (addr == IO_ADDR_B);
    // Store from the boot region into instruction memory
    assign boot_wr = pc[30] && addr[29];

    // Writeback result still in flight for the store's rs2
    assign fwd_hit = writes_rd(wb_opcode) && (wb_rd != '0) && (wb_rd == rs2);

    always_comb begin
        case (funct3_store_e'(funct3))
            FNC_SB:  st_mask = 4'b0001;
            FNC_SH:  st_mask = 4'b0011;
            FNC_SW:  st_mask = 4'b1111;
            default: st_mask = 4'b0000;
        endcase
    end

    always_comb begin
        ctrl           = '0;
        ctrl.load_kind = NONE;
        ctrl.offset    = addr[1:0];
        if (in_valid) begin
            case (opcode)
                OPC_STORE: begin
                    ctrl.din_sel = fwd_hit;
                    if (is_io) begin
                        ctrl.io_en  = 1'b1;
                        ctrl.io_sel = (addr == IO_ADDR_B);
                    end else if (boot_wr) begin
                        ctrl.imem_wr = 1'b1;
                        ctrl.we      = st_mask << addr[1:0];
                    end else begin
                        ctrl.dmem_en = 1'b1;
                        ctrl.we      = st_mask << addr[1:0];
                    end
                end
                OPC_LOAD: begin
                    // I/O addresses read back from the data memory
                    ctrl.dmem_en = 1'b1;
                    case (funct3_load_e'(funct3))
                        FNC_LB:  ctrl.load_kind = BYTE_S;
                        FNC_LBU: ctrl.load_kind = BYTE_U;
                        FNC_LH:  ctrl.load_kind = HALF_S;
                        FNC_LHU: ctrl.load_kind = HALF_U;
                        FNC_LW:  ctrl.load_kind = WORD;
                        default: ctrl.load_kind = NONE;
                    endcase
                end
                default: begin
                    ctrl.dmem_en = 1'b0;
                end
            endcase
        end
    end

    assign br_inst = (opcode == OPC_BRANCH) || (opcode == OPC_JAL) || (opcode == OPC_JALR);

    // Byte mask only with a memory target
    a_we_has_target: assert property (@(posedge clk) disable iff (reset)
        (ctrl.we != '0) |-> (ctrl.dmem_en || ctrl.imem_wr));

    a_io_not_dmem: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.io_en && ctrl.dmem_en));

endmodule

/* source/dmem_bank.sv */
`timescale 1ns/1ps

module dmem_bank #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                    clk,
    input  logic                    reset,
    input  mem_stage_pkg::mem_req_t req,
    input  logic                    in_valid,
    output mem_stage_pkg::word_t    rdata,
    output mem_stage_pkg::load_tag_t tag,
    output mem_stage_pkg::io_req_t  io_out,
    output logic                    imem_wr_strobe,
    output mem_stage_pkg::word_t    imem_wr_addr,
    output mem_stage_pkg::word_t    imem_wr_data
);

    import mem_stage_pkg::*;

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    word_t            mem [DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             wr_en;
    logic             is_load;

    // Word index wraps at the memory depth
    assign idx     = IDX_W'((req.addr >> 2) % DMEM_WORDS);
    assign wr_en   = in_valid && req.ctrl.dmem_en && (req.ctrl.we != '0);
    assign is_load = in_valid && (req.ctrl.load_kind != NONE);

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wr_en && req.ctrl.we[b]) begin
                mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_load) begin
            rdata <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tag <= '0;
        end else begin
            tag.valid     <= is_load;
            tag.load_kind <= req.ctrl.load_kind;
            tag.offset    <= req.ctrl.offset;
        end
    end

    // I/O and boot writes leave the stage one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            io_out.valid   <= 1'b0;
            imem_wr_strobe <= 1'b0;
        end else begin
            io_out.valid   <= in_valid && req.ctrl.io_en;
            imem_wr_strobe <= in_valid && req.ctrl.imem_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && req.ctrl.io_en) begin
            io_out.io_sel <= req.ctrl.io_sel;
            io_out.data   <= req.wdata;
        end
        if (in_valid && req.ctrl.imem_wr) begin
            imem_wr_addr <= req.addr;
            imem_wr_data <= req.wdata;
        end
    end

    // A write never produces a load tag
    a_write_no_tag: assert property (@(posedge clk) disable iff (reset)
        wr_en |=> !tag.valid);

endmodule

/* source/load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  mem_stage_pkg::word_t     rdata,
    input  mem_stage_pkg::load_tag_t tag,
    output logic                     wb_valid,
    output mem_stage_pkg::word_t     wb_data
);

    import mem_stage_pkg::*;

    word_t shifted;

    // Addressed byte moves down to lane 0
    assign shifted = rdata >> {tag.offset, 3'b000};

    always_comb begin
        case (tag.load_kind)
            BYTE_S: begin
                wb_data = {{24{shifted[7]}}, shifted[7:0]};
            end
            BYTE_U: begin
                wb_data = {24'h0, shifted[7:0]};
            end
            HALF_S: begin
                wb_data = {{16{shifted[15]}}, shifted[15:0]};
            end
            HALF_U: begin
                wb_data = {16'h0, shifted[15:0]};
            end
            WORD: begin
                wb_data = shifted;
            end
            default: begin
                wb_data = shifted;
            end
        endcase
    end

    assign wb_valid = tag.valid;

endmodule

/* source/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  mem_stage_pkg::word_t   inst,
    input  mem_stage_pkg::word_t   wb_inst,
    input  mem_stage_pkg::word_t   pc,
    input  mem_stage_pkg::word_t   addr,
    input  mem_stage_pkg::word_t   rs2_data,
    input  mem_stage_pkg::word_t   wb_value,
    output logic                   wb_valid,
    output mem_stage_pkg::word_t   wb_data,
    output logic                   br_inst,
    output mem_stage_pkg::io_req_t io_out,
    output logic                   imem_wr_strobe,
    output mem_stage_pkg::word_t   imem_wr_addr,
    output mem_stage_pkg::word_t   imem_wr_data
);

    import mem_stage_pkg::*;

    mem_ctrl_t ctrl;
    mem_req_t  req;
    word_t     store_src;
    word_t     rdata;
    load_tag_t tag;

    mem_control ctrl_i (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .inst     (inst),
        .wb_inst  (wb_inst),
        .pc       (pc),
        .addr     (addr),
        .ctrl     (ctrl),
        .br_inst  (br_inst)
    );

    // Forwarded writeback value or register file data
    assign store_src = ctrl.din_sel ? wb_value : rs2_data;

    assign req.ctrl  = ctrl;
    assign req.addr  = addr;
    assign req.wdata = store_src << {addr[1:0], 3'b000};

    dmem_bank #(
        .DMEM_WORDS (DMEM_WORDS)
    ) bank_i (
        .clk            (clk),
        .reset          (reset),
        .req            (req),
        .in_valid       (in_valid),
        .rdata          (rdata),
        .tag            (tag),
        .io_out         (io_out),
        .imem_wr_strobe (imem_wr_strobe),
        .imem_wr_addr   (imem_wr_addr),
        .imem_wr_data   (imem_wr_data)
    );

    load_align align_i (
        .rdata    (rdata),
        .tag      (tag),
        .wb_valid (wb_valid),
        .wb_data  (wb_data)
    );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* sim/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb;

    import rv_isa_pkg::*;
    import mem_stage_pkg::*;

    localparam int WORDS       = 64;
    localparam int N_RAND      = 20;
    localparam int NUM_OPS     = WORDS + 2 * N_RAND + 60 + 4 + 8 + 7 + 1;
    localparam int WATCHDOG_NS = NUM_OPS * 4 * 4 + 200;
    localparam logic [2:0] LOAD_F3 [5] = '{FNC_LB, FNC_LH, FNC_LW, FNC_LBU, FNC_LHU};

    logic    clk;
    logic    reset;
    logic    in_valid;
    word_t   inst;
    word_t   wb_inst;
    word_t   pc;
    word_t   addr;
    word_t   rs2_data;
    word_t   wb_value;
    logic    wb_valid;
    word_t   wb_data;
    logic    br_inst;
    io_req_t io_out;
    logic    imem_wr_strobe;
    word_t   imem_wr_addr;
    word_t   imem_wr_data;

    logic [15:0] lfsr = 16'd51049;
    word_t       shadow [WORDS];
    word_t       exp_loads [$];
    io_req_t     exp_io_d;
    io_req_t     exp_io_q;
    logic        exp_imem_d;
    logic        exp_imem_q;
    word_t       exp_imem_addr_d;
    word_t       exp_imem_addr_q;
    word_t       exp_imem_data_d;
    word_t       exp_imem_data_q;
    int          word_errs = 0;
    int          io_errs = 0;
    int          bit_errs = 0;
    int          other_errs = 0;

    tb_clock clock_i (
        .clk   (clk),
        .reset (reset)
    );

    mem_stage #(
        .DMEM_WORDS (WORDS)
    ) dut_i (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .inst           (inst),
        .wb_inst        (wb_inst),
        .pc             (pc),
        .addr           (addr),
        .rs2_data       (rs2_data),
        .wb_value       (wb_value),
        .wb_valid       (wb_valid),
        .wb_data        (wb_data),
        .br_inst        (br_inst),
        .io_out         (io_out),
        .imem_wr_strobe (imem_wr_strobe),
        .imem_wr_addr   (imem_wr_addr),
        .imem_wr_data   (imem_wr_data)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t make_inst(input opcode_e op, input logic [2:0] f3,
                                        input reg_idx_t rd, input reg_idx_t rs2);
        return {7'd0, rs2, 5'd1, f3, rd, op, 2'b11};
    endfunction

    function automatic logic forwards(input word_t st, input word_t wb);
        logic writer;
        writer = wb[6:2] inside {OPC_LOAD, OPC_ARI_ITYPE, OPC_ARI_RTYPE, OPC_JAL,
                                 OPC_JALR, OPC_LUI, OPC_AUIPC};
        return writer && (wb[11:7] != 5'd0) && (wb[11:7] == st[24:20]);
    endfunction

    // Shift down, cut to width, then extend
    function automatic word_t ref_load(input word_t w, input logic [2:0] f3,
                                       input logic [1:0] off);
        word_t s;
        s = w >> (8 * off);
        case (funct3_load_e'(f3))
            FNC_LB:  return {{24{s[7]}}, s[7:0]};
            FNC_LBU: return {24'h0, s[7:0]};
            FNC_LH:  return {{16{s[15]}}, s[15:0]};
            FNC_LHU: return {16'h0, s[15:0]};
            default: return s;
        endcase
    endfunction

    function automatic logic ref_branch(input word_t i_inst);
        return i_inst[6:2] inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            word_errs++;
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_io(input io_req_t got, input io_req_t exp);
        if (got !== exp) begin
            io_errs++;
            $display("[ERROR] %0d ns: io_out is %b/%b/%h, expected %b/%b/%h", $time,
                     got.valid, got.io_sel, got.data, exp.valid, exp.io_sel, exp.data);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            bit_errs++;
            $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic issue(input logic v, input word_t i_inst, input word_t i_wb_inst,
                         input word_t i_pc, input word_t i_addr, input word_t i_rs2,
                         input word_t i_wbv);
        logic [3:0] mask;
        word_t      lanes;
        int         idx;
        @(negedge clk);
        in_valid = v;
        inst     = i_inst;
        wb_inst  = i_wb_inst;
        pc       = i_pc;
        addr     = i_addr;
        rs2_data = i_rs2;
        wb_value = i_wbv;
        idx   = int'((i_addr >> 2) % WORDS);
        lanes = (forwards(i_inst, i_wb_inst) ? i_wbv : i_rs2) << (8 * i_addr[1:0]);
        case (i_inst[14:12])
            3'b000:  mask = 4'b0001;
            3'b001:  mask = 4'b0011;
            default: mask = 4'b1111;
        endcase
        mask = mask << i_addr[1:0];
        exp_io_d   = '0;
        exp_imem_d = 1'b0;
        if (v && i_inst[6:2] == OPC_STORE) begin
            if (i_addr == IO_ADDR_A || i_addr == IO_ADDR_B) begin
                exp_io_d.valid  = 1'b1;
                exp_io_d.io_sel = (i_addr == IO_ADDR_B);
                exp_io_d.data   = lanes;
            end else if (i_pc[30] && i_addr[29]) begin
                exp_imem_d      = 1'b1;
                exp_imem_addr_d = i_addr;
                exp_imem_data_d = lanes;
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (mask[b]) shadow[idx][8*b +: 8] = lanes[8*b +: 8];
                end
            end
        end else if (v && i_inst[6:2] == OPC_LOAD) begin
            exp_loads.push_back(ref_load(shadow[idx], i_inst[14:12], i_addr[1:0]));
        end
        #1;
        check_bit(br_inst, ref_branch(i_inst), "br_inst");
    endtask

    task automatic mem_op(input word_t i_inst, input word_t i_addr, input word_t data);
        issue(1'b1, i_inst, '0, '0, i_addr, data, ~data);
    endtask

    always @(posedge clk) begin
        exp_io_q        <= exp_io_d;
        exp_imem_q      <= exp_imem_d;
        exp_imem_addr_q <= exp_imem_addr_d;
        exp_imem_data_q <= exp_imem_data_d;
    end

    always @(negedge clk) begin
        if (reset === 1'b0) begin
            if (wb_valid === 1'b1 && exp_loads.size() == 0) begin
                other_errs++;
                $display("A load result came back at %0d ns with no load outstanding", $time);
            end else if (wb_valid === 1'b1) begin
                check_word(wb_data, exp_loads.pop_front(), "wb_data");
            end
            if (exp_io_q.valid || io_out.valid !== 1'b0) begin
                check_io(io_out, exp_io_q);
            end
            check_bit(imem_wr_strobe, exp_imem_q, "imem_wr_strobe");
            if (exp_imem_q === 1'b1) begin
                check_word(imem_wr_addr, exp_imem_addr_q, "imem_wr_addr");
                check_word(imem_wr_data, exp_imem_data_q, "imem_wr_data");
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [1:0] kind;
        logic [1:0] off;
        word_t      a;
        word_t      sw_i;
        word_t      lw_i;
        in_valid        = 1'b0;
        inst            = '0;
        wb_inst         = '0;
        pc              = '0;
        addr            = '0;
        rs2_data        = '0;
        wb_value        = '0;
        exp_io_d        = '0;
        exp_imem_d      = 1'b0;
        exp_imem_addr_d = '0;
        exp_imem_data_d = '0;
        sw_i = make_inst(OPC_STORE, FNC_SW, 5'd0, 5'd2);
        lw_i = make_inst(OPC_LOAD, FNC_LW, 5'd3, 5'd0);
        while (reset !== 1'b0) @(negedge clk);

        for (int w = 0; w < WORDS; w++) begin
            mem_op(sw_i, word_t'(w * 4), rand_bits(32));
        end
        // Random SB, SH and SW, each read back as a word
        for (int n = 0; n < N_RAND; n++) begin
            kind = 2'(rand_bits(2) % 3);
            off  = 2'(rand_bits(2));
            if (kind == 2'd1) off[0] = 1'b0;
            if (kind == 2'd2) off = 2'd0;
            a = (rand_bits(6) << 2) | word_t'(off);
            mem_op(make_inst(OPC_STORE, {1'b0, kind}, 5'd0, 5'd2), a, rand_bits(32));
            mem_op(lw_i, {a[31:2], 2'b00}, '0);
        end
        for (int w = 0; w < 3; w++) begin
            a = rand_bits(6) << 2;
            for (int o = 0; o < 4; o++) begin
                for (int k = 0; k < 5; k++) begin
                    mem_op(make_inst(OPC_LOAD, LOAD_F3[k], 5'd4, 5'd0), a | word_t'(o), '0);
                end
            end
        end

        mem_op(sw_i, IO_ADDR_A, rand_bits(32));
        mem_op(sw_i, IO_ADDR_B, rand_bits(32));
        // Data memory words 2 and 6
        mem_op(lw_i, IO_ADDR_A, '0);
        mem_op(lw_i, IO_ADDR_B, '0);

        issue(1'b1, make_inst(OPC_STORE, FNC_SW, 5'd0, 5'd5),
              make_inst(OPC_ARI_RTYPE, 3'd0, 5'd5, 5'd0), '0, 32'h40, rand_bits(32), rand_bits(32));
        mem_op(lw_i, 32'h40, '0);
        issue(1'b1, make_inst(OPC_STORE, FNC_SW, 5'd0, 5'd0),
              make_inst(OPC_LOAD, FNC_LW, 5'd0, 5'd0), '0, 32'h44, rand_bits(32), rand_bits(32));
        mem_op(lw_i, 32'h44, '0);
        issue(1'b1, make_inst(OPC_STORE, FNC_SW, 5'd0, 5'd7),
              make_inst(OPC_STORE, FNC_SW, 5'd7, 5'd3), '0, 32'h48, rand_bits(32), rand_bits(32));
        mem_op(lw_i, 32'h48, '0);
        issue(1'b1, make_inst(OPC_STORE, FNC_SB, 5'd0, 5'd9),
              make_inst(OPC_JAL, 3'd0, 5'd9, 5'd0), '0, 32'h4d, rand_bits(32), rand_bits(32));
        mem_op(lw_i, 32'h4c, '0);

        issue(1'b1, make_inst(OPC_BRANCH, 3'd0, 5'd0, 5'd1), '0, '0, '0, '0, '0);
        issue(1'b1, make_inst(OPC_JAL, 3'd0, 5'd1, 5'd0), '0, '0, '0, '0, '0);
        issue(1'b1, make_inst(OPC_JALR, 3'd0, 5'd1, 5'd0), '0, '0, '0, '0, '0);
        issue(1'b1, make_inst(OPC_LUI, 3'd0, 5'd1, 5'd0), '0, '0, '0, '0, '0);
        issue(1'b0, make_inst(OPC_BRANCH, 3'd0, 5'd0, 5'd1), '0, '0, '0, '0, '0);
        // Boot region store goes to instruction memory only
        issue(1'b1, sw_i, '0, 32'h4000_0000, 32'h2000_0050, rand_bits(32), '0);
        mem_op(lw_i, 32'h50, '0);
        issue(1'b0, '0, '0, '0, '0, '0, '0);

        while (exp_loads.size() != 0) @(negedge clk);
        @(negedge clk);
        #1;
        $display("Error counts: word %0d, io %0d, bit %0d, other %0d",
                 word_errs, io_errs, bit_errs, other_errs);
        if (word_errs + io_errs + bit_errs + other_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tb.f */
source/rv_isa_pkg.sv
source/mem_stage_pkg.sv
source/mem_control.sv
source/dmem_bank.sv
source/load_align.sv
source/mem_stage.sv
sim/tb_clock.sv
sim/mem_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module mem_stage_tb -o mem_stage_sim

./obj_dir/mem_stage_sim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "All checks passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
